//--- mm_cfg_pkg.sv
`default_nettype none

package mm_cfg_pkg;

  // Bus and field widths
  localparam int unsigned DATA_W = 32;
  localparam int unsigned ADDR_W = 3;
  localparam int unsigned LEN_W  = 16;

  // Number of host-visible words
  localparam int unsigned NUM_REGS = 7;

  // Word offsets of the job registers
  localparam logic [ADDR_W-1:0] REG_OP_A   = 3'd0;
  localparam logic [ADDR_W-1:0] REG_OP_B   = 3'd1;
  localparam logic [ADDR_W-1:0] REG_LEN    = 3'd2;
  localparam logic [ADDR_W-1:0] REG_START  = 3'd3;
  localparam logic [ADDR_W-1:0] REG_CLEAR  = 3'd4;
  localparam logic [ADDR_W-1:0] REG_STATUS = 3'd5;
  localparam logic [ADDR_W-1:0] REG_RESULT = 3'd6;

  // Status register layout
  localparam int unsigned STATUS_BUSY_BIT = 0;
  localparam int unsigned STATUS_DONE_BIT = 1;

endpackage

`default_nettype wire

//--- mm_ctrl_pkg.sv
`default_nettype none

package mm_ctrl_pkg;

  // Controller states, in the order the FSM walks them
  typedef enum logic [2:0] {
    LATCH_RST,
    IDLE,
    STARTING,
    COMPUTING,
    FINISHED
  } ctrl_state_e;

  // Elements per tile
  localparam int unsigned DEF_TILE_LEN = 8;

  // Cycles spent in the operand load phase
  localparam int unsigned DEF_LOAD_CYCLES = 2;

endpackage

`default_nettype wire

//--- mm_reg_slave.sv
`timescale 1ns/1ps
`default_nettype none

module mm_reg_slave (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                wb_cyc_i,
  input  logic                                wb_stb_i,
  input  logic                                wb_we_i,
  input  logic [mm_cfg_pkg::ADDR_W-1:0]       wb_adr_i,
  input  logic [mm_cfg_pkg::DATA_W-1:0]       wb_dat_i,
  input  logic [mm_cfg_pkg::DATA_W/8-1:0]     wb_sel_i,
  output logic [mm_cfg_pkg::DATA_W-1:0]       wb_dat_o,
  output logic                                wb_ack_o,
  input  logic                                busy_i,
  input  logic                                done_i,
  input  logic [mm_cfg_pkg::DATA_W-1:0]       result_i,
  output logic                                start_o,
  output logic                                clear_o,
  output logic [mm_cfg_pkg::DATA_W-1:0]       op_a_o,
  output logic [mm_cfg_pkg::DATA_W-1:0]       op_b_o,
  output logic [mm_cfg_pkg::LEN_W-1:0]        len_o
);

  localparam int unsigned DW    = mm_cfg_pkg::DATA_W;
  localparam int unsigned SEL_W = mm_cfg_pkg::DATA_W / 8;

  logic          req, wr_req, rd_req, start_wr;
  logic          ack_q, start_q, clear_q, done_q;
  logic [DW-1:0] op_a_q, op_b_q, result_q, rdata_q, status;
  logic [mm_cfg_pkg::LEN_W-1:0] len_q;

  // Byte-lane merge for the operand registers
  function automatic logic [DW-1:0] merge_bytes(input logic [DW-1:0]    old_val,
                                                input logic [DW-1:0]    new_val,
                                                input logic [SEL_W-1:0] sel);
    logic [DW-1:0] res;
    res = old_val;
    for (int b = 0; b < SEL_W; b++) begin
      if (sel[b]) begin
        res[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return res;
  endfunction

  // New request only on the first cycle, so a held strobe is acked once
  assign req      = wb_cyc_i & wb_stb_i & ~ack_q;
  assign wr_req   = req & wb_we_i;
  assign rd_req   = req & ~wb_we_i;
  assign start_wr = wr_req && (wb_adr_i == mm_cfg_pkg::REG_START) && wb_dat_i[0] && !busy_i;

  always_comb begin
    status = '0;
    status[mm_cfg_pkg::STATUS_BUSY_BIT] = busy_i;
    status[mm_cfg_pkg::STATUS_DONE_BIT] = done_q;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q    <= 1'b0;
      start_q  <= 1'b0;
      clear_q  <= 1'b0;
      done_q   <= 1'b0;
      result_q <= '0;
      op_a_q   <= '0;
      op_b_q   <= '0;
      len_q    <= '0;
    end else begin
      ack_q   <= req;
      start_q <= start_wr;
      clear_q <= wr_req && (wb_adr_i == mm_cfg_pkg::REG_CLEAR) && wb_dat_i[0];
      if (wr_req && wb_adr_i == mm_cfg_pkg::REG_OP_A) begin
        op_a_q <= merge_bytes(op_a_q, wb_dat_i, wb_sel_i);
      end
      if (wr_req && wb_adr_i == mm_cfg_pkg::REG_OP_B) begin
        op_b_q <= merge_bytes(op_b_q, wb_dat_i, wb_sel_i);
      end
      if (wr_req && wb_adr_i == mm_cfg_pkg::REG_LEN) begin
        len_q <= wb_dat_i[mm_cfg_pkg::LEN_W-1:0];
      end
      // Sticky done, dropped by the next accepted start or a soft clear
      if (done_i) begin
        done_q   <= 1'b1;
        result_q <= result_i;
      end else if (start_wr || clear_q) begin
        done_q <= 1'b0;
      end
    end
  end

  // Read data goes out together with the ack
  always_ff @(posedge clk_i) begin
    if (rd_req) begin
      case (wb_adr_i)
        mm_cfg_pkg::REG_OP_A:   rdata_q <= op_a_q;
        mm_cfg_pkg::REG_OP_B:   rdata_q <= op_b_q;
        mm_cfg_pkg::REG_LEN:    rdata_q <= DW'(len_q);
        mm_cfg_pkg::REG_STATUS: rdata_q <= status;
        mm_cfg_pkg::REG_RESULT: rdata_q <= result_q;
        default:                rdata_q <= '0;
      endcase
    end
  end

  assign wb_dat_o = rdata_q;
  assign wb_ack_o = ack_q;
  assign start_o  = start_q;
  assign clear_o  = clear_q;
  assign op_a_o   = op_a_q;
  assign op_b_o   = op_b_q;
  assign len_o    = len_q;

endmodule

`default_nettype wire

//--- mm_tiler.sv
`timescale 1ns/1ps
`default_nettype none

module mm_tiler #(
  parameter int unsigned TILE_LEN = 8
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clear_i,
  input  logic                          setback_i,
  input  logic                          start_i,
  input  logic [mm_cfg_pkg::DATA_W-1:0] op_a_i,
  input  logic [mm_cfg_pkg::DATA_W-1:0] op_b_i,
  input  logic [mm_cfg_pkg::LEN_W-1:0]  len_i,
  output logic                          valid_o,
  output logic [mm_cfg_pkg::DATA_W-1:0] op_a_o,
  output logic [mm_cfg_pkg::DATA_W-1:0] op_b_o,
  output logic [mm_cfg_pkg::LEN_W-1:0]  len_o,
  output logic [mm_cfg_pkg::LEN_W-1:0]  num_tiles_o,
  output logic [mm_cfg_pkg::LEN_W-1:0]  last_tile_len_o
);

  localparam int unsigned LW = mm_cfg_pkg::LEN_W;

  logic                          valid_q;
  logic [mm_cfg_pkg::DATA_W-1:0] op_a_q, op_b_q;
  logic [LW-1:0]                 len_q, rem;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (clear_i || setback_i) begin
      valid_q <= 1'b0;
    end else if (start_i) begin
      valid_q <= 1'b1;
    end
  end

  // Snapshot of the job, the host may reprogram while it runs
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      op_a_q <= op_a_i;
      op_b_q <= op_b_i;
      len_q  <= len_i;
    end
  end

  // Ceiling division and remainder of the last tile
  assign rem             = LW'(32'(len_q) % TILE_LEN);
  assign num_tiles_o     = LW'((32'(len_q) + TILE_LEN - 1) / TILE_LEN);
  assign last_tile_len_o = (rem == '0) ? LW'(TILE_LEN) : rem;

  assign valid_o = valid_q;
  assign op_a_o  = op_a_q;
  assign op_b_o  = op_b_q;
  assign len_o   = len_q;

endmodule

`default_nettype wire

//--- mm_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module mm_ctrl #(
  parameter int unsigned TILE_LEN = 8
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            wb_cyc_i,
  input  logic                            wb_stb_i,
  input  logic                            wb_we_i,
  input  logic [mm_cfg_pkg::ADDR_W-1:0]   wb_adr_i,
  input  logic [mm_cfg_pkg::DATA_W-1:0]   wb_dat_i,
  input  logic [mm_cfg_pkg::DATA_W/8-1:0] wb_sel_i,
  output logic [mm_cfg_pkg::DATA_W-1:0]   wb_dat_o,
  output logic                            wb_ack_o,
  input  logic                            loaded_i,
  input  logic                            last_i,
  input  logic [mm_cfg_pkg::DATA_W-1:0]   result_i,
  output logic                            irq_o,
  output logic                            clear_o,
  output logic                            flush_o,
  output logic                            first_load_o,
  output logic                            busy_o,
  output logic [mm_cfg_pkg::DATA_W-1:0]   op_a_o,
  output logic [mm_cfg_pkg::DATA_W-1:0]   op_b_o,
  output logic [mm_cfg_pkg::LEN_W-1:0]    num_tiles_o,
  output logic [mm_cfg_pkg::LEN_W-1:0]    last_tile_len_o
);

  mm_ctrl_pkg::ctrl_state_e state_q, state_d;

  logic                          soft_clear, slave_start, start_pending_q;
  logic                          tiler_setback, tiler_valid, busy, done;
  logic [mm_cfg_pkg::DATA_W-1:0] reg_op_a, reg_op_b;
  logic [mm_cfg_pkg::LEN_W-1:0]  reg_len;

  mm_reg_slave i_reg_slave (
    .clk_i    ( clk_i       ),
    .rst_ni   ( rst_ni      ),
    .wb_cyc_i ( wb_cyc_i    ),
    .wb_stb_i ( wb_stb_i    ),
    .wb_we_i  ( wb_we_i     ),
    .wb_adr_i ( wb_adr_i    ),
    .wb_dat_i ( wb_dat_i    ),
    .wb_sel_i ( wb_sel_i    ),
    .wb_dat_o ( wb_dat_o    ),
    .wb_ack_o ( wb_ack_o    ),
    .busy_i   ( busy        ),
    .done_i   ( done        ),
    .result_i ( result_i    ),
    .start_o  ( slave_start ),
    .clear_o  ( soft_clear  ),
    .op_a_o   ( reg_op_a    ),
    .op_b_o   ( reg_op_b    ),
    .len_o    ( reg_len     )
  );

  mm_tiler #(
    .TILE_LEN ( TILE_LEN )
  ) i_tiler (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .clear_i         ( soft_clear      ),
    .setback_i       ( tiler_setback   ),
    .start_i         ( slave_start     ),
    .op_a_i          ( reg_op_a        ),
    .op_b_i          ( reg_op_b        ),
    .len_i           ( reg_len         ),
    .valid_o         ( tiler_valid     ),
    .op_a_o          ( op_a_o          ),
    .op_b_o          ( op_b_o          ),
    .len_o           (                 ),
    .num_tiles_o     ( num_tiles_o     ),
    .last_tile_len_o ( last_tile_len_o )
  );

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= mm_ctrl_pkg::LATCH_RST;
    end else if (soft_clear) begin
      state_q <= mm_ctrl_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Start stays pending until the tiler is set back
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_pending_q <= 1'b0;
    end else if (soft_clear || tiler_setback) begin
      start_pending_q <= 1'b0;
    end else if (slave_start) begin
      start_pending_q <= 1'b1;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      mm_ctrl_pkg::LATCH_RST: state_d = mm_ctrl_pkg::IDLE;
      mm_ctrl_pkg::IDLE: begin
        if (start_pending_q && tiler_valid) begin
          state_d = mm_ctrl_pkg::STARTING;
        end
      end
      mm_ctrl_pkg::STARTING: begin
        if (loaded_i) begin
          state_d = mm_ctrl_pkg::COMPUTING;
        end
      end
      mm_ctrl_pkg::COMPUTING: begin
        if (last_i) begin
          state_d = mm_ctrl_pkg::FINISHED;
        end
      end
      default: state_d = mm_ctrl_pkg::IDLE;
    endcase
  end

  assign tiler_setback = (state_q == mm_ctrl_pkg::IDLE) && (state_d == mm_ctrl_pkg::STARTING);
  assign busy          = (state_q == mm_ctrl_pkg::STARTING) || (state_q == mm_ctrl_pkg::COMPUTING);
  assign done          = state_q == mm_ctrl_pkg::FINISHED;
  assign first_load_o  = state_q == mm_ctrl_pkg::STARTING;
  assign flush_o       = done;
  assign irq_o         = done;
  assign busy_o        = busy;
  assign clear_o       = soft_clear || (state_q == mm_ctrl_pkg::LATCH_RST);

endmodule

`default_nettype wire

//--- mm_engine.sv
`timescale 1ns/1ps
`default_nettype none

module mm_engine #(
  parameter int unsigned TILE_LEN    = 8,
  parameter int unsigned LOAD_CYCLES = 2
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clear_i,
  input  logic                          first_load_i,
  input  logic                          flush_i,
  input  logic [mm_cfg_pkg::DATA_W-1:0] op_a_i,
  input  logic [mm_cfg_pkg::DATA_W-1:0] op_b_i,
  input  logic [mm_cfg_pkg::LEN_W-1:0]  num_tiles_i,
  input  logic [mm_cfg_pkg::LEN_W-1:0]  last_tile_len_i,
  output logic                          loaded_o,
  output logic                          last_o,
  output logic [mm_cfg_pkg::DATA_W-1:0] result_o
);

  localparam int unsigned DW     = mm_cfg_pkg::DATA_W;
  localparam int unsigned LW     = mm_cfg_pkg::LEN_W;
  localparam int unsigned LOAD_W = (LOAD_CYCLES > 1) ? $clog2(LOAD_CYCLES) : 1;

  logic [LOAD_W-1:0] load_cnt_q;
  logic              computing_q, last_tile, elem_last;
  logic [LW-1:0]     tile_idx_q, elem_idx_q, cur_tile_len, elem_g;
  logic [DW-1:0]     acc_q, opa_val, opb_val, prod;

  assign loaded_o = first_load_i && (load_cnt_q == LOAD_W'(LOAD_CYCLES - 1));

  // Shortened length on the final tile
  assign last_tile    = tile_idx_q == (num_tiles_i - LW'(1));
  assign cur_tile_len = last_tile ? last_tile_len_i : LW'(TILE_LEN);
  assign elem_last    = elem_idx_q == (cur_tile_len - LW'(1));
  assign last_o       = computing_q && ((num_tiles_i == '0) || (last_tile && elem_last));

  // Global element index and its generated operands
  assign elem_g  = LW'(tile_idx_q * TILE_LEN) + elem_idx_q;
  assign opa_val = op_a_i + DW'(elem_g);
  assign opb_val = op_b_i ^ DW'(elem_g);
  assign prod    = opa_val * opb_val;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      load_cnt_q  <= '0;
      computing_q <= 1'b0;
      tile_idx_q  <= '0;
      elem_idx_q  <= '0;
    end else if (clear_i || flush_i) begin
      load_cnt_q  <= '0;
      computing_q <= 1'b0;
      tile_idx_q  <= '0;
      elem_idx_q  <= '0;
    end else begin
      if (first_load_i) begin
        load_cnt_q <= loaded_o ? '0 : load_cnt_q + LOAD_W'(1);
      end
      if (loaded_o) begin
        computing_q <= 1'b1;
      end
      if (computing_q) begin
        if (last_o) begin
          computing_q <= 1'b0;
          tile_idx_q  <= '0;
          elem_idx_q  <= '0;
        end else if (elem_last) begin
          elem_idx_q <= '0;
          tile_idx_q <= tile_idx_q + LW'(1);
        end else begin
          elem_idx_q <= elem_idx_q + LW'(1);
        end
      end
    end
  end

  // Accumulator survives flush so the slave can still latch it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q <= '0;
    end else if (clear_i || loaded_o) begin
      acc_q <= '0;
    end else if (computing_q && num_tiles_i != '0) begin
      acc_q <= acc_q + prod;
    end
  end

  assign result_o = acc_q;

endmodule

`default_nettype wire

//--- mm_top.sv
`timescale 1ns/1ps
`default_nettype none

module mm_top #(
  parameter int unsigned TILE_LEN    = mm_ctrl_pkg::DEF_TILE_LEN,
  parameter int unsigned LOAD_CYCLES = mm_ctrl_pkg::DEF_LOAD_CYCLES
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            wb_cyc_i,
  input  logic                            wb_stb_i,
  input  logic                            wb_we_i,
  input  logic [mm_cfg_pkg::ADDR_W-1:0]   wb_adr_i,
  input  logic [mm_cfg_pkg::DATA_W-1:0]   wb_dat_i,
  input  logic [mm_cfg_pkg::DATA_W/8-1:0] wb_sel_i,
  output logic [mm_cfg_pkg::DATA_W-1:0]   wb_dat_o,
  output logic                            wb_ack_o,
  output logic                            irq_o
);

  logic                          clear, flush, first_load, loaded, last;
  logic [mm_cfg_pkg::DATA_W-1:0] op_a, op_b, result;
  logic [mm_cfg_pkg::LEN_W-1:0]  num_tiles, last_tile_len;

  mm_ctrl #(
    .TILE_LEN ( TILE_LEN )
  ) i_ctrl (
    .clk_i           ( clk_i         ),
    .rst_ni          ( rst_ni        ),
    .wb_cyc_i        ( wb_cyc_i      ),
    .wb_stb_i        ( wb_stb_i      ),
    .wb_we_i         ( wb_we_i       ),
    .wb_adr_i        ( wb_adr_i      ),
    .wb_dat_i        ( wb_dat_i      ),
    .wb_sel_i        ( wb_sel_i      ),
    .wb_dat_o        ( wb_dat_o      ),
    .wb_ack_o        ( wb_ack_o      ),
    .loaded_i        ( loaded        ),
    .last_i          ( last          ),
    .result_i        ( result        ),
    .irq_o           ( irq_o         ),
    .clear_o         ( clear         ),
    .flush_o         ( flush         ),
    .first_load_o    ( first_load    ),
    .busy_o          (               ),
    .op_a_o          ( op_a          ),
    .op_b_o          ( op_b          ),
    .num_tiles_o     ( num_tiles     ),
    .last_tile_len_o ( last_tile_len )
  );

  mm_engine #(
    .TILE_LEN    ( TILE_LEN    ),
    .LOAD_CYCLES ( LOAD_CYCLES )
  ) i_engine (
    .clk_i           ( clk_i         ),
    .rst_ni          ( rst_ni        ),
    .clear_i         ( clear         ),
    .first_load_i    ( first_load    ),
    .flush_i         ( flush         ),
    .op_a_i          ( op_a          ),
    .op_b_i          ( op_b          ),
    .num_tiles_i     ( num_tiles     ),
    .last_tile_len_i ( last_tile_len ),
    .loaded_o        ( loaded        ),
    .last_o          ( last          ),
    .result_o        ( result        )
  );

endmodule

`default_nettype wire

//--- tb_mm_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mm_top;

  localparam int unsigned DW = mm_cfg_pkg::DATA_W;
  localparam int unsigned AW = mm_cfg_pkg::ADDR_W;
  localparam int CLK_PERIOD  = 40;
  localparam int RST_CYCLES  = 8;
  localparam int WD_MARGIN   = 50;

  // Expected status words from the register layout
  localparam logic [DW-1:0] STATUS_BUSY = DW'(1) << mm_cfg_pkg::STATUS_BUSY_BIT;
  localparam logic [DW-1:0] STATUS_DONE = DW'(1) << mm_cfg_pkg::STATUS_DONE_BIT;

  logic            clk_i, rst_ni;
  logic            wb_cyc_i, wb_stb_i, wb_we_i;
  logic [AW-1:0]   wb_adr_i;
  logic [DW-1:0]   wb_dat_i;
  logic [DW/8-1:0] wb_sel_i;
  logic [DW-1:0]   wb_dat_o;
  logic            wb_ack_o, irq_o;

  logic [DW-1:0] case_a[$], case_b[$], case_exp[$];
  int            case_len[$];
  int            error_count, tests_passed, tests_failed, wd_cycles, long_idx;

  mm_top dut (
    .clk_i    ( clk_i    ),
    .rst_ni   ( rst_ni   ),
    .wb_cyc_i ( wb_cyc_i ),
    .wb_stb_i ( wb_stb_i ),
    .wb_we_i  ( wb_we_i  ),
    .wb_adr_i ( wb_adr_i ),
    .wb_dat_i ( wb_dat_i ),
    .wb_sel_i ( wb_sel_i ),
    .wb_dat_o ( wb_dat_o ),
    .wb_ack_o ( wb_ack_o ),
    .irq_o    ( irq_o    )
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic check_value(input string name, input logic [DW-1:0] exp,
                             input logic [DW-1:0] act);
    if (act !== exp) begin
      $display("[ERROR] t=%0t %s expected %h got %h", $time, name, exp, act);
      error_count++;
    end
  endtask

  task automatic idle_gap();
    repeat ($urandom % 4) @(posedge clk_i);
  endtask

  // Classic cycle held until ack is seen at a falling edge
  task automatic write_reg(input logic [AW-1:0] adr, input logic [DW-1:0] dat);
    @(posedge clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= 1'b1;
    wb_adr_i <= adr;
    wb_dat_i <= dat;
    wb_sel_i <= '1;
    do begin
      @(negedge clk_i);
    end while (!wb_ack_o);
    @(posedge clk_i);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
  endtask

  task automatic read_reg(input logic [AW-1:0] adr, output logic [DW-1:0] dat);
    @(posedge clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= 1'b0;
    wb_adr_i <= adr;
    do begin
      @(negedge clk_i);
    end while (!wb_ack_o);
    dat = wb_dat_o;
    @(posedge clk_i);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
  endtask

  task automatic wait_for_irq(input int max_cycles, output bit seen);
    int n;
    seen = 1'b0;
    n = 0;
    while (!seen && n < max_cycles) begin
      @(negedge clk_i);
      seen = irq_o;
      n++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (error_count == errs_before) begin
      $display("%s: pass", name);
      tests_passed++;
    end else begin
      $display("%s: FAIL", name);
      tests_failed++;
    end
  endtask

  // Lines starting with # are comments
  task automatic load_cases();
    int            fd, code, l;
    string         line;
    logic [DW-1:0] a, b, e;
    fd = $fopen("mm_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open mm_cases.txt");
      error_count++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        code = $fgets(line, fd);
        if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
          if ($sscanf(line, "%h %h %h %h", a, b, l, e) == 4) begin
            case_a.push_back(a);
            case_b.push_back(b);
            case_len.push_back(l);
            case_exp.push_back(e);
          end
        end
      end
      $fclose(fd);
      if (case_len.size() == 0) begin
        $display("No cases found in mm_cases.txt");
        error_count++;
      end
    end
  endtask

  task automatic program_job(input int idx);
    idle_gap();
    write_reg(mm_cfg_pkg::REG_OP_A, case_a[idx]);
    idle_gap();
    write_reg(mm_cfg_pkg::REG_OP_B, case_b[idx]);
    idle_gap();
    write_reg(mm_cfg_pkg::REG_LEN, DW'(case_len[idx]));
    idle_gap();
    write_reg(mm_cfg_pkg::REG_START, DW'(1));
  endtask

  task automatic run_case(input int idx);
    logic [DW-1:0] rd;
    bit            seen;
    program_job(idx);
    // Read right away while the job is still in its load phase
    read_reg(mm_cfg_pkg::REG_STATUS, rd);
    check_value("STATUS", STATUS_BUSY, rd);
    wait_for_irq(case_len[idx] + WD_MARGIN, seen);
    if (!seen) begin
      $display("Case %0d: no interrupt within %0d cycles", idx, case_len[idx] + WD_MARGIN);
      error_count++;
    end
    idle_gap();
    read_reg(mm_cfg_pkg::REG_STATUS, rd);
    check_value("STATUS", STATUS_DONE, rd);
    read_reg(mm_cfg_pkg::REG_RESULT, rd);
    check_value("RESULT", case_exp[idx], rd);
  endtask

  initial begin
    wait (wd_cycles > 0);
    repeat (wd_cycles) @(posedge clk_i);
    $display("Timeout after %0d clock cycles, the run did not complete", wd_cycles);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    logic [DW-1:0] rd;
    bit            seen;
    int            errs, total;
    void'($urandom(32'h4bea));
    clk_i    = 1'b0;
    rst_ni   = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    wb_sel_i = '0;
    load_cases();

    // Budget covers every job run below plus the extra long ones
    long_idx = 0;
    total    = RST_CYCLES + WD_MARGIN;
    foreach (case_len[i]) begin
      total += case_len[i] + WD_MARGIN;
      if (case_len[i] > case_len[long_idx]) begin
        long_idx = i;
      end
    end
    if (case_len.size() > 0) begin
      wd_cycles = total + 4 * (case_len[long_idx] + WD_MARGIN);
    end

    repeat (RST_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;

    if (case_len.size() > 0) begin
      errs = error_count;
      @(negedge clk_i);
      check_value("irq_o", '0, DW'(irq_o));
      read_reg(mm_cfg_pkg::REG_STATUS, rd);
      check_value("STATUS", '0, rd);
      read_reg(mm_cfg_pkg::REG_RESULT, rd);
      check_value("RESULT", '0, rd);
      report_test("reset state", errs);

      foreach (case_len[i]) begin
        errs = error_count;
        run_case(i);
        report_test($sformatf("case %0d len %0d", i, case_len[i]), errs);
      end

      // Host reprograms and restarts while the long job runs
      errs = error_count;
      program_job(long_idx);
      write_reg(mm_cfg_pkg::REG_OP_A, ~case_a[long_idx]);
      write_reg(mm_cfg_pkg::REG_OP_B, ~case_b[long_idx]);
      write_reg(mm_cfg_pkg::REG_START, DW'(1));
      wait_for_irq(case_len[long_idx] + WD_MARGIN, seen);
      if (!seen) begin
        $display("Overlap: no interrupt for the running job");
        error_count++;
      end
      read_reg(mm_cfg_pkg::REG_RESULT, rd);
      check_value("RESULT", case_exp[long_idx], rd);
      wait_for_irq(case_len[long_idx] + WD_MARGIN, seen);
      if (seen) begin
        $display("Overlap: a second interrupt followed the ignored start");
        error_count++;
      end
      report_test("start while busy", errs);

      // Abort the long job and check that a fresh job still computes correctly
      errs = error_count;
      program_job(long_idx);
      repeat (10) @(posedge clk_i);
      write_reg(mm_cfg_pkg::REG_CLEAR, DW'(1));
      wait_for_irq(case_len[long_idx] + WD_MARGIN, seen);
      if (seen) begin
        $display("Abort: an interrupt arrived for the cleared job");
        error_count++;
      end
      read_reg(mm_cfg_pkg::REG_STATUS, rd);
      check_value("STATUS", '0, rd);
      run_case((long_idx + 1) % case_len.size());
      report_test("clear mid-run", errs);
    end

    $display("%0d tests passed, %0d tests failed, %0d check errors",
             tests_passed, tests_failed, error_count);
    if (error_count == 0 && tests_failed == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- mm_cases.txt
# op_a     op_b     len  expected   (all hex, one job per line)
# expected = sum over i < len of (op_a + i) * (op_b ^ i), 32-bit wrap
12345678 9abcdef0 0000 00000000
00010003 00010005 0001 0008000f
00000010 000000ff 0003 00003298
00000005 00000100 0008 00004518
00010000 00010000 000d 009c028a
00000002 00000400 0040 0022dd20
00000003 000000ff 0015 00010243
ffffffff 00000100 0010 00006c60
00001000 00000200 0020 042308b0

//--- src.f
mm_cfg_pkg.sv
mm_ctrl_pkg.sv
mm_reg_slave.sv
mm_tiler.sv
mm_ctrl.sv
mm_engine.sv
mm_top.sv
tb_mm_top.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and decide on the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -f src.f --top-module tb_mm_top -o sim_mm_top
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_mm_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Test OK" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
